// File: src/ni_pkg.sv
package ni_pkg;

    // network and channel sizing
    localparam int NUM_VC       = 2;    // one DMA channel per virtual channel
    localparam int VC_IDX_W     = 1;
    localparam int CREDIT_DEPTH = 4;    // router input buffer slots per VC
    localparam int CREDIT_CNT_W = $clog2(CREDIT_DEPTH + 1);
    localparam int FPAY_W       = 32;
    localparam int FLIT_W       = 2 + NUM_VC + FPAY_W;
    localparam int EADDR_W      = 8;
    localparam int CLASS_W      = 2;
    localparam int SIZE_W       = 10;   // transfer size in words
    localparam int REG_ADDR_W   = 4;
    localparam int SLAVE_ADDR_W = 7;
    localparam int ERR_W        = 2;

    typedef logic [31:0]             word_t;
    typedef logic [EADDR_W-1:0]      eaddr_t;
    typedef logic [CLASS_W-1:0]      class_t;
    typedef logic [SIZE_W-1:0]       size_t;
    typedef logic [NUM_VC-1:0]       vc_mask_t;
    typedef logic [VC_IDX_W-1:0]     vc_idx_t;
    typedef logic [FLIT_W-1:0]       flit_t;
    typedef logic [1:0]              flit_flag_t;
    typedef logic [REG_ADDR_W-1:0]   reg_addr_t;
    typedef logic [SLAVE_ADDR_W-1:0] slave_addr_t;

    // per-channel register field, channel number sits above it
    localparam reg_addr_t REG_STATUS     = 4'd0;
    localparam reg_addr_t REG_IRQ_CTRL   = 4'd1;
    localparam reg_addr_t REG_SEND_SIZE  = 4'd3;
    localparam reg_addr_t REG_SEND_START = 4'd4;
    localparam reg_addr_t REG_SEND_DEST  = 4'd5;
    localparam reg_addr_t REG_SEND_CTRL  = 4'd6;
    localparam reg_addr_t REG_ERRORS     = 4'd12;

    localparam int SEND_DONE_EN_LOC  = 0;
    localparam int ERROR_EN_LOC      = 3;
    localparam int SEND_DONE_ISR_LOC = 4;
    localparam int ERROR_ISR_LOC     = 7;
    localparam int STATUS_ISR_LOC    = 8;   // done isr mirrored in STATUS

    localparam int ERR_ILLEGAL_START_LOC = 0;
    localparam int ERR_ZERO_SIZE_LOC     = 1;

    localparam int CLASS_LOC = 16;  // in SEND_DEST and header payload
    localparam int SRC_LOC   = 8;

    localparam flit_flag_t HDR_FLAG  = 2'b10;
    localparam flit_flag_t BDY_FLAG  = 2'b00;
    localparam flit_flag_t TAIL_FLAG = 2'b01;

    typedef enum logic [1:0] {
        SEND_IDLE,
        SEND_WAIT_GRANT,
        SEND_HEADER,
        SEND_BODY
    } send_state_e;

endpackage

// File: src/ni_slave_regs.sv
`timescale 1ns/1ps

module ni_slave_regs (
    input  logic                clk,
    input  logic                reset,
    input  ni_pkg::word_t       s_dat_i,
    input  ni_pkg::slave_addr_t s_addr_i,
    input  logic                s_stb_i,
    input  logic                s_we_i,
    output ni_pkg::word_t       s_dat_o,
    output logic                s_ack_o,
    input  ni_pkg::vc_mask_t    send_busy_i,
    input  ni_pkg::vc_mask_t    send_done_i,
    output ni_pkg::vc_mask_t    start_o,
    output ni_pkg::size_t       send_size_o       [ni_pkg::NUM_VC],
    output ni_pkg::word_t       send_start_addr_o [ni_pkg::NUM_VC],
    output ni_pkg::eaddr_t      send_dest_o       [ni_pkg::NUM_VC],
    output ni_pkg::class_t      send_class_o      [ni_pkg::NUM_VC],
    output logic                irq_o
);
    import ni_pkg::*;

    vc_idx_t          ch;
    reg_addr_t        field;
    logic             wr_en;
    logic             clear_errors;
    logic [ERR_W-1:0] err_flags [NUM_VC];
    vc_mask_t         err_vec;
    logic             done_en;
    logic             err_en;
    logic             done_isr;
    logic             err_isr;

    assign ch    = s_addr_i[REG_ADDR_W +: VC_IDX_W];
    assign field = s_addr_i[REG_ADDR_W-1:0];
    assign wr_en = s_stb_i & s_we_i & ~s_ack_o;   // write lands in the strobe cycle

    // error clear from either IRQ_CTRL or ERRORS
    assign clear_errors = wr_en && s_dat_i[ERROR_ISR_LOC]
                          && (field == REG_IRQ_CTRL || field == REG_ERRORS);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_ack_o <= 1'b0;
        end else begin
            s_ack_o <= s_stb_i & ~s_ack_o;   // single cycle ack
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_o <= '0;
            for (int i = 0; i < NUM_VC; i++) begin
                send_size_o[i]       <= '0;
                send_start_addr_o[i] <= '0;
                send_dest_o[i]       <= '0;
                send_class_o[i]      <= '0;
                err_flags[i]         <= '0;
            end
        end else begin
            start_o <= '0;
            for (int i = 0; i < NUM_VC; i++) begin
                if (clear_errors) err_flags[i] <= '0;
                if (wr_en && ch == vc_idx_t'(i)) begin
                    case (field)
                        REG_SEND_SIZE:  send_size_o[i] <= s_dat_i[SIZE_W-1:0];
                        REG_SEND_START: send_start_addr_o[i] <= s_dat_i;
                        REG_SEND_DEST: begin
                            send_dest_o[i]  <= s_dat_i[EADDR_W-1:0];
                            send_class_o[i] <= s_dat_i[CLASS_LOC +: CLASS_W];
                        end
                        REG_SEND_CTRL: begin
                            // pending start counts as busy too
                            if (send_busy_i[i] || start_o[i]) begin
                                err_flags[i][ERR_ILLEGAL_START_LOC] <= 1'b1;
                            end else if (send_size_o[i] == '0) begin
                                err_flags[i][ERR_ZERO_SIZE_LOC] <= 1'b1;
                            end else begin
                                start_o[i] <= 1'b1;
                            end
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_VC; i++) err_vec[i] = |err_flags[i];
    end

    // isr bits only set when no slave write is taken
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_en  <= 1'b0;
            err_en   <= 1'b0;
            done_isr <= 1'b0;
            err_isr  <= 1'b0;
        end else if (wr_en) begin
            if (field == REG_IRQ_CTRL) begin
                done_en <= s_dat_i[SEND_DONE_EN_LOC];
                err_en  <= s_dat_i[ERROR_EN_LOC];
                if (s_dat_i[SEND_DONE_ISR_LOC]) done_isr <= 1'b0;   // write one to clear
            end
            if (clear_errors) err_isr <= 1'b0;
        end else begin
            if (|send_done_i) done_isr <= 1'b1;
            if (|err_vec) err_isr <= 1'b1;
        end
    end

    assign irq_o = (done_isr & done_en) | (err_isr & err_en);

    always_comb begin
        s_dat_o = '0;
        case (field)
            REG_IRQ_CTRL: begin
                s_dat_o[SEND_DONE_EN_LOC]  = done_en;
                s_dat_o[ERROR_EN_LOC]      = err_en;
                s_dat_o[SEND_DONE_ISR_LOC] = done_isr;
                s_dat_o[ERROR_ISR_LOC]     = err_isr;
            end
            REG_SEND_SIZE:  s_dat_o[SIZE_W-1:0] = send_size_o[ch];
            REG_SEND_START: s_dat_o = send_start_addr_o[ch];
            REG_SEND_DEST: begin
                s_dat_o[EADDR_W-1:0]          = send_dest_o[ch];
                s_dat_o[CLASS_LOC +: CLASS_W] = send_class_o[ch];
            end
            REG_ERRORS:     s_dat_o[ERR_W-1:0] = err_flags[ch];
            default: begin  // STATUS and anything unmapped
                s_dat_o[NUM_VC-1:0]    = send_busy_i;
                s_dat_o[STATUS_ISR_LOC] = done_isr;
            end
        endcase
    end

endmodule

// File: src/ni_send_channel.sv
`timescale 1ns/1ps

module ni_send_channel (
    input  logic          clk,
    input  logic          reset,
    input  logic          start_i,
    input  ni_pkg::size_t size_i,
    input  ni_pkg::word_t start_addr_i,
    input  logic          grant_i,
    input  logic          vc_full_i,
    input  logic          m_ack_i,
    output logic          request_o,
    output logic          busy_o,
    output logic          hdr_wr_o,
    output logic          rd_stb_o,
    output ni_pkg::word_t rd_addr_o,
    output logic          last_o,
    output logic          done_o
);
    import ni_pkg::*;

    send_state_e state;
    size_t       words_left;
    logic        ack_mine;

    // only this channel writes its VC while granted, so full cannot rise
    // under a pending strobe and the strobe stays up until the ack
    assign rd_stb_o = (state == SEND_BODY) && grant_i && !vc_full_i;
    assign ack_mine = m_ack_i & rd_stb_o;

    assign hdr_wr_o = (state == SEND_HEADER) && grant_i && !vc_full_i;

    assign last_o = (state == SEND_BODY) && (words_left == size_t'(1));   // tail word

    assign request_o = (state != SEND_IDLE);
    assign busy_o    = (state != SEND_IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= SEND_IDLE;
            words_left <= '0;
            done_o     <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state)
                SEND_IDLE: begin
                    if (start_i) begin
                        words_left <= size_i;   // size checked nonzero upstream
                        state      <= SEND_WAIT_GRANT;
                    end
                end
                SEND_WAIT_GRANT: begin
                    if (grant_i) state <= SEND_HEADER;
                end
                SEND_HEADER: begin
                    if (hdr_wr_o) state <= SEND_BODY;
                end
                SEND_BODY: begin
                    if (ack_mine) begin
                        words_left <= words_left - size_t'(1);
                        if (last_o) begin
                            state  <= SEND_IDLE;
                            done_o <= 1'b1;     // also drops request and busy
                        end
                    end
                end
                default: state <= SEND_IDLE;
            endcase
        end
    end

    // read address walks one word per ack
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_addr_o <= '0;
        end else if (state == SEND_IDLE && start_i) begin
            rd_addr_o <= start_addr_i;
        end else if (ack_mine) begin
            rd_addr_o <= rd_addr_o + word_t'(1);
        end
    end

endmodule

// File: src/ni_send_arbiter.sv
`timescale 1ns/1ps

module ni_send_arbiter (
    input  logic             clk,
    input  logic             reset,
    input  ni_pkg::vc_mask_t request_i,
    output ni_pkg::vc_mask_t grant_o
);
    import ni_pkg::*;

    vc_idx_t  last_q;   // last winner
    vc_idx_t  win_idx;
    vc_mask_t pick;
    logic     found;

    // search starts one past the last winner
    always_comb begin
        int idx;
        pick    = '0;
        win_idx = last_q;
        found   = 1'b0;
        for (int k = 1; k <= NUM_VC; k++) begin
            idx = (int'(last_q) + k) % NUM_VC;
            if (!found && request_i[idx]) begin
                pick[idx] = 1'b1;
                win_idx   = vc_idx_t'(idx);
                found     = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant_o <= '0;
            last_q  <= vc_idx_t'(NUM_VC - 1);   // channel 0 wins first
        end else if ((grant_o & request_i) == '0) begin
            grant_o <= pick;   // hold while the owner keeps requesting
            if (found) last_q <= win_idx;
        end
    end

endmodule

// File: src/ni_ovc_credit.sv
`timescale 1ns/1ps

module ni_ovc_credit (
    input  logic             clk,
    input  logic             reset,
    input  logic             flit_wr_i,
    input  ni_pkg::vc_mask_t grant_i,
    input  ni_pkg::vc_mask_t credit_in_i,
    output ni_pkg::vc_mask_t full_o
);
    import ni_pkg::*;

    logic [CREDIT_CNT_W-1:0] depth [NUM_VC];   // flits not yet credited
    vc_mask_t                wr_vc;

    assign wr_vc = flit_wr_i ? grant_i : '0;

    for (genvar i = 0; i < NUM_VC; i++) begin : g_vc
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                depth[i] <= '0;
            end else begin
                case ({wr_vc[i], credit_in_i[i]})
                    2'b10:   depth[i] <= depth[i] + 1'b1;
                    2'b01:   depth[i] <= depth[i] - 1'b1;
                    default: ;   // both or neither, no change
                endcase
            end
        end

        assign full_o[i] = (depth[i] == CREDIT_CNT_W'(CREDIT_DEPTH));
    end

endmodule

// File: src/ni_packetizer.sv
`timescale 1ns/1ps

module ni_packetizer (
    input  ni_pkg::vc_mask_t grant_i,
    input  ni_pkg::eaddr_t   current_e_addr_i,
    input  ni_pkg::eaddr_t   send_dest_i  [ni_pkg::NUM_VC],
    input  ni_pkg::class_t   send_class_i [ni_pkg::NUM_VC],
    input  ni_pkg::vc_mask_t hdr_wr_i,
    input  ni_pkg::vc_mask_t rd_stb_i,
    input  ni_pkg::vc_mask_t last_i,
    input  ni_pkg::word_t    rd_addr_i    [ni_pkg::NUM_VC],
    input  ni_pkg::word_t    m_send_dat_i,
    input  logic             m_send_ack_i,
    output ni_pkg::word_t    m_send_addr_o,
    output logic             m_send_stb_o,
    output logic             m_send_cyc_o,
    output ni_pkg::flit_t    flit_out_o,
    output logic             flit_out_wr_o
);
    import ni_pkg::*;

    vc_idx_t           sel;
    logic              send_hdr;
    logic              ack_wr;
    logic [FPAY_W-1:0] hdr_payload;
    logic [FPAY_W-1:0] payload;
    flit_flag_t        flag;

    // one-hot grant to index
    always_comb begin
        sel = '0;
        for (int i = 0; i < NUM_VC; i++) begin
            if (grant_i[i]) sel = vc_idx_t'(i);
        end
    end

    assign m_send_addr_o = rd_addr_i[sel];
    assign m_send_stb_o  = |(rd_stb_i & grant_i);
    assign m_send_cyc_o  = m_send_stb_o;

    assign send_hdr      = |(hdr_wr_i & grant_i);
    assign ack_wr        = m_send_ack_i & m_send_stb_o;   // each ack is one flit
    assign flit_out_wr_o = send_hdr | ack_wr;

    always_comb begin
        hdr_payload                        = '0;
        hdr_payload[EADDR_W-1:0]           = send_dest_i[sel];
        hdr_payload[SRC_LOC +: EADDR_W]    = current_e_addr_i;
        hdr_payload[CLASS_LOC +: CLASS_W]  = send_class_i[sel];
    end

    assign flag    = send_hdr ? HDR_FLAG : (last_i[sel] ? TAIL_FLAG : BDY_FLAG);
    assign payload = send_hdr ? hdr_payload : m_send_dat_i[FPAY_W-1:0];

    assign flit_out_o = {flag, grant_i, payload};   // vc field is the grant itself

endmodule

// File: src/ni_send_top.sv
`timescale 1ns/1ps

module ni_send_top (
    input  logic                clk,
    input  logic                reset,
    input  ni_pkg::eaddr_t      current_e_addr_i,
    input  ni_pkg::word_t       s_dat_i,
    input  ni_pkg::slave_addr_t s_addr_i,
    input  logic                s_stb_i,
    input  logic                s_we_i,
    output ni_pkg::word_t       s_dat_o,
    output logic                s_ack_o,
    output ni_pkg::word_t       m_send_addr_o,
    output logic                m_send_stb_o,
    output logic                m_send_cyc_o,
    input  ni_pkg::word_t       m_send_dat_i,
    input  logic                m_send_ack_i,
    output ni_pkg::flit_t       flit_out_o,
    output logic                flit_out_wr_o,
    input  ni_pkg::vc_mask_t    credit_in_i,
    output logic                irq_o
);
    import ni_pkg::*;

    vc_mask_t start, busy, done, request, grant, vc_full;
    vc_mask_t hdr_wr, rd_stb, last;
    size_t    send_size       [NUM_VC];
    word_t    send_start_addr [NUM_VC];
    eaddr_t   send_dest       [NUM_VC];
    class_t   send_class      [NUM_VC];
    word_t    rd_addr         [NUM_VC];

    ni_slave_regs u_regs (
        .clk, .reset, .s_dat_i, .s_addr_i, .s_stb_i, .s_we_i, .s_dat_o, .s_ack_o,
        .send_busy_i(busy), .send_done_i(done), .start_o(start),
        .send_size_o(send_size), .send_start_addr_o(send_start_addr),
        .send_dest_o(send_dest), .send_class_o(send_class), .irq_o
    );

    for (genvar i = 0; i < NUM_VC; i++) begin : g_chan
        ni_send_channel u_chan (
            .clk, .reset,
            .start_i(start[i]), .size_i(send_size[i]), .start_addr_i(send_start_addr[i]),
            .grant_i(grant[i]), .vc_full_i(vc_full[i]), .m_ack_i(m_send_ack_i),
            .request_o(request[i]), .busy_o(busy[i]), .hdr_wr_o(hdr_wr[i]),
            .rd_stb_o(rd_stb[i]), .rd_addr_o(rd_addr[i]), .last_o(last[i]),
            .done_o(done[i])
        );
    end

    ni_send_arbiter u_arb (
        .clk, .reset, .request_i(request), .grant_o(grant)
    );

    ni_ovc_credit u_credit (
        .clk, .reset, .flit_wr_i(flit_out_wr_o), .grant_i(grant),
        .credit_in_i, .full_o(vc_full)
    );

    ni_packetizer u_pkt (
        .grant_i(grant), .current_e_addr_i,
        .send_dest_i(send_dest), .send_class_i(send_class),
        .hdr_wr_i(hdr_wr), .rd_stb_i(rd_stb), .last_i(last), .rd_addr_i(rd_addr),
        .m_send_dat_i, .m_send_ack_i, .m_send_addr_o, .m_send_stb_o, .m_send_cyc_o,
        .flit_out_o, .flit_out_wr_o
    );

endmodule

// File: verification/ni_tb_clock.sv
`timescale 1ns/1ps

module ni_tb_clock (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;   // 8 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

// File: verification/ni_send_properties.sv
`timescale 1ns/1ps

module ni_send_properties (
    input logic             clk,
    input logic             reset,
    input ni_pkg::flit_t    flit_out_o,
    input logic             flit_out_wr_o,
    input logic             m_send_stb_o,
    input logic             m_send_cyc_o,
    input logic             m_send_ack_i,
    input ni_pkg::word_t    m_send_addr_o,
    input ni_pkg::vc_mask_t credit_in_i
);
    import ni_pkg::*;

    int       uncredited [NUM_VC];
    vc_mask_t wr_vc;

    assign wr_vc = flit_out_wr_o ? flit_out_o[FPAY_W +: NUM_VC] : '0;

    // flits sent minus credits seen, per VC
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_VC; i++) uncredited[i] <= 0;
        end else begin
            for (int i = 0; i < NUM_VC; i++) begin
                uncredited[i] <= uncredited[i] + int'(wr_vc[i]) - int'(credit_in_i[i]);
            end
        end
    end

    a_one_vc: assert property (@(posedge clk) disable iff (reset)
        flit_out_wr_o |-> $onehot(flit_out_o[FPAY_W +: NUM_VC]))
        else $error("flit written with a VC field that is not one-hot");

    // cycle comes with the strobe, both held until the ack
    a_stb_cyc: assert property (@(posedge clk) disable iff (reset)
        (m_send_stb_o && !m_send_ack_i) |-> m_send_cyc_o ##1 (m_send_stb_o && m_send_cyc_o))
        else $error("read strobe without cycle, or dropped before its ack");

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        (m_send_stb_o && !m_send_ack_i) |=> (m_send_addr_o == $past(m_send_addr_o)))
        else $error("read address moved before the ack");

    for (genvar i = 0; i < NUM_VC; i++) begin : g_credit
        a_credit: assert property (@(posedge clk) disable iff (reset)
            uncredited[i] <= CREDIT_DEPTH)
            else $error("VC %0d has more uncredited flits than buffer slots", i);
    end

endmodule

// File: verification/ni_send_tb.sv
`timescale 1ns/1ps

module ni_send_tb;
    import ni_pkg::*;

    localparam word_t DATA_KEY     = 32'h5a3c_96e1;   // memory data is address xor this
    localparam int    MAX_SIZE     = 20;
    localparam int    NUM_PKTS     = 18;
    localparam int    CYC_PER_FLIT = 60;               // worst case with credits withheld
    localparam int    PKT_TIMEOUT  = (MAX_SIZE + 1) * CYC_PER_FLIT;
    localparam int    CLK_PERIOD   = 8;

    logic        clk, reset;
    eaddr_t      current_e_addr_i;
    word_t       s_dat_i, s_dat_o, m_send_addr_o, m_send_dat_i;
    slave_addr_t s_addr_i;
    logic        s_stb_i, s_we_i, s_ack_o, m_send_stb_o, m_send_cyc_o, m_send_ack_i;
    flit_t       flit_out_o;
    logic        flit_out_wr_o, irq_o;
    vc_mask_t    credit_in_i;

    integer seed = 32'he612f7a5;
    int     errors = 0;
    int     checks = 0;
    flit_t  exp_mem [NUM_VC][MAX_SIZE+1];   // predicted flits per channel
    int     exp_len [NUM_VC];
    int     exp_pos [NUM_VC];
    int     pending [NUM_VC];                // flits the sink still owes credit for
    int     flit_count = 0;
    logic   hold, stress, pkt_open;
    int     open_vc;

    ni_tb_clock u_clk (.clk_o(clk), .reset_o(reset));

    ni_send_top uut (
        .clk, .reset, .current_e_addr_i, .s_dat_i, .s_addr_i, .s_stb_i, .s_we_i,
        .s_dat_o, .s_ack_o, .m_send_addr_o, .m_send_stb_o, .m_send_cyc_o,
        .m_send_dat_i, .m_send_ack_i, .flit_out_o, .flit_out_wr_o, .credit_in_i, .irq_o
    );

    bind ni_send_top ni_send_properties u_props (
        .clk(clk), .reset(reset), .flit_out_o(flit_out_o), .flit_out_wr_o(flit_out_wr_o),
        .m_send_stb_o(m_send_stb_o), .m_send_cyc_o(m_send_cyc_o),
        .m_send_ack_i(m_send_ack_i), .m_send_addr_o(m_send_addr_o),
        .credit_in_i(credit_in_i)
    );

    function automatic int rand_range(input int lo, input int hi);
        logic [31:0] r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    task automatic check(input string name, input logic [63:0] expv, input logic [63:0] actv);
        checks++;
        if (expv !== actv) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", name, expv, actv);
        end
    endtask

    task automatic bus_access(input int ch, input reg_addr_t field, input logic we,
                              input word_t wdata, output word_t rdata);
        int waited;
        @(posedge clk);
        s_addr_i <= slave_addr_t'({vc_idx_t'(ch), field});
        s_we_i   <= we;
        s_dat_i  <= wdata;
        s_stb_i  <= 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!s_ack_o && waited < 10);
        if (!s_ack_o) begin
            errors++;
            $display("slave port gave no ack to an access");
        end
        rdata = s_dat_o;
        @(posedge clk);
        s_stb_i <= 1'b0;
        s_we_i  <= 1'b0;
    endtask

    task automatic reg_write(input int ch, input reg_addr_t field, input word_t data);
        word_t unused;
        bus_access(ch, field, 1'b1, data, unused);
    endtask

    task automatic reg_read(input int ch, input reg_addr_t field, output word_t data);
        bus_access(ch, field, 1'b0, '0, data);
    endtask

    // program a channel and predict its packet
    task automatic config_packet(input int ch, input int size);
        word_t    start;
        eaddr_t   dest;
        class_t   cls;
        vc_mask_t vc;
        word_t    hdr;
        start = $random(seed);
        dest  = $random(seed);
        cls   = $random(seed);
        vc    = '0;
        vc[ch] = 1'b1;
        reg_write(ch, REG_SEND_SIZE, word_t'(size));
        reg_write(ch, REG_SEND_START, start);
        reg_write(ch, REG_SEND_DEST, word_t'(dest) | (word_t'(cls) << 16));
        hdr = word_t'(dest) | (word_t'(current_e_addr_i) << 8) | (word_t'(cls) << 16);
        exp_mem[ch][0] = {HDR_FLAG, vc, hdr};
        for (int k = 1; k <= size; k++) begin
            exp_mem[ch][k] = {(k == size) ? TAIL_FLAG : BDY_FLAG, vc,
                              (start + word_t'(k - 1)) ^ DATA_KEY};
        end
        exp_len[ch] = size + 1;
        exp_pos[ch] = 0;
    endtask

    task automatic wait_packet(input int ch);
        int    n;
        word_t st;
        n = 0;
        while (exp_pos[ch] < exp_len[ch] && n < PKT_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_pos[ch] < exp_len[ch]) begin
            errors++;
            $display("packet on channel %0d did not complete", ch);
        end
        n = 0;
        do begin
            reg_read(ch, REG_STATUS, st);
            n++;
        end while (st[ch] && n < 20);
        if (st[ch]) begin
            errors++;
            $display("channel %0d stays busy after its tail flit", ch);
        end
    endtask

    // memory model, acks after 0 to 3 idle cycles
    initial begin
        word_t addr;
        forever begin
            @(negedge clk);
            if (!reset && m_send_stb_o) begin
                check("read cycle with strobe", 1, m_send_cyc_o);
                addr = m_send_addr_o;
                repeat (rand_range(0, 3)) @(negedge clk);
                @(posedge clk);
                m_send_ack_i <= 1'b1;
                m_send_dat_i <= addr ^ DATA_KEY;
                @(posedge clk);
                m_send_ack_i <= 1'b0;
            end
        end
    end

    // network sink and scoreboard
    always @(negedge clk) begin
        flit_t f;
        int    v;
        if (!reset && flit_out_wr_o) begin
            f = flit_out_o;
            v = f[FPAY_W] ? 0 : 1;
            flit_count++;
            check("flit vc one-hot", 1, $onehot(f[FPAY_W +: NUM_VC]));
            if (pkt_open && v != open_vc) begin
                errors++;
                $display("flit on vc %0d interleaved with an open packet on vc %0d",
                         v, open_vc);
            end
            if (f[FLIT_W-1 -: 2] == HDR_FLAG) begin
                pkt_open = 1'b1;
                open_vc  = v;
            end else if (f[FLIT_W-1 -: 2] == TAIL_FLAG) begin
                pkt_open = 1'b0;
            end
            if (exp_pos[v] >= exp_len[v]) begin
                errors++;
                $display("unexpected flit %h on vc %0d", f, v);
            end else begin
                check("flit", exp_mem[v][exp_pos[v]], f);
                exp_pos[v]++;
            end
            pending[v]++;
            check("outstanding flits within credit depth", 1, pending[v] <= CREDIT_DEPTH);
        end
    end

    // credit return after a random delay, unless withheld
    always @(posedge clk) begin
        vc_mask_t m;
        m = '0;
        if (!reset) begin
            for (int v = 0; v < NUM_VC; v++) begin
                if (pending[v] > 0 && !hold && rand_range(0, 2) == 0) begin
                    m[v] = 1'b1;
                    pending[v]--;
                end
            end
        end
        credit_in_i <= m;
    end

    // long random credit stalls while stress is on
    initial begin
        forever begin
            @(negedge clk);
            if (stress) begin
                hold = 1'b1;
                repeat (rand_range(10, 40)) @(negedge clk);
                hold = 1'b0;
                repeat (rand_range(2, 8)) @(negedge clk);
            end else begin
                hold = 1'b0;
            end
        end
    end

    initial begin
        #(NUM_PKTS * PKT_TIMEOUT * CLK_PERIOD);
        $display("timeout: the run did not finish in time");
        $display("errors: %0d, checks: %0d", errors + 1, checks);
        $display("Test failures found");
        $finish;
    end

    initial begin
        word_t w, r;
        int    sz0, sz1;
        s_dat_i = '0;
        s_addr_i = '0;
        s_stb_i = 1'b0;
        s_we_i = 1'b0;
        m_send_dat_i = '0;
        m_send_ack_i = 1'b0;
        credit_in_i = '0;
        current_e_addr_i = 8'h3b;
        hold = 1'b0;
        stress = 1'b0;
        pkt_open = 1'b0;
        open_vc = 0;
        for (int v = 0; v < NUM_VC; v++) begin
            exp_len[v] = 0;
            exp_pos[v] = 0;
            pending[v] = 0;
        end
        @(negedge reset);
        @(posedge clk);

        // register readback
        for (int ch = 0; ch < NUM_VC; ch++) begin
            w = $random(seed);
            reg_write(ch, REG_SEND_SIZE, w);
            reg_read(ch, REG_SEND_SIZE, r);
            check("readback send_size", w & 32'h0000_03ff, r);
            w = $random(seed);
            reg_write(ch, REG_SEND_START, w);
            reg_read(ch, REG_SEND_START, r);
            check("readback send_start", w, r);
            w = $random(seed);
            reg_write(ch, REG_SEND_DEST, w);
            reg_read(ch, REG_SEND_DEST, r);
            check("readback send_dest", w & 32'h0003_00ff, r);
        end
        w = $random(seed);
        reg_write(0, REG_IRQ_CTRL, w & 32'h9);
        reg_read(0, REG_IRQ_CTRL, r);
        check("readback irq_ctrl", w & 32'h9, r);
        reg_write(0, REG_IRQ_CTRL, 32'h0);

        // single packets
        repeat (8) begin
            sz0 = rand_range(0, 1);
            config_packet(sz0, rand_range(1, MAX_SIZE));
            reg_write(sz0, REG_SEND_CTRL, 32'h0);
            wait_packet(sz0);
        end

        // both channels started close together
        repeat (2) begin
            config_packet(0, rand_range(1, MAX_SIZE));
            config_packet(1, rand_range(1, MAX_SIZE));
            reg_write(0, REG_SEND_CTRL, 32'h0);
            reg_write(1, REG_SEND_CTRL, 32'h0);
            wait_packet(0);
            wait_packet(1);
        end

        // back-pressure from withheld credits
        stress = 1'b1;
        repeat (2) begin
            sz0 = rand_range(12, MAX_SIZE);
            sz1 = rand_range(12, MAX_SIZE);
            config_packet(0, sz0);
            config_packet(1, sz1);
            reg_write(0, REG_SEND_CTRL, 32'h0);
            reg_write(1, REG_SEND_CTRL, 32'h0);
            wait_packet(0);
            wait_packet(1);
        end
        stress = 1'b0;

        // send done interrupt
        reg_write(0, REG_IRQ_CTRL, 32'h90);
        reg_read(0, REG_IRQ_CTRL, r);
        check("isr cleared", 32'h0, r);
        reg_write(0, REG_IRQ_CTRL, 32'h1);
        config_packet(1, rand_range(1, MAX_SIZE));
        reg_write(1, REG_SEND_CTRL, 32'h0);
        wait_packet(1);
        @(negedge clk);
        check("irq with done enabled", 1, irq_o);
        reg_read(0, REG_IRQ_CTRL, r);
        check("done isr set", 32'h11, r);
        reg_read(0, REG_STATUS, r);
        check("status done isr", 1, r[8]);
        reg_write(0, REG_IRQ_CTRL, 32'h0);
        @(negedge clk);
        check("irq with done disabled", 0, irq_o);
        reg_read(0, REG_IRQ_CTRL, r);
        check("done isr held", 32'h10, r);
        reg_write(0, REG_IRQ_CTRL, 32'h10);
        reg_read(0, REG_IRQ_CTRL, r);
        check("done isr write one clear", 32'h0, r);

        // start while busy and zero size
        reg_write(0, REG_IRQ_CTRL, 32'h8);
        config_packet(0, MAX_SIZE);
        reg_write(0, REG_SEND_CTRL, 32'h0);
        reg_write(0, REG_SEND_CTRL, 32'h0);
        reg_read(0, REG_ERRORS, r);
        check("illegal start flag", 32'h1, r);
        reg_read(0, REG_IRQ_CTRL, r);
        check("error isr set", 32'h88, r & 32'h88);
        @(negedge clk);
        check("irq on error", 1, irq_o);
        wait_packet(0);
        reg_write(1, REG_SEND_SIZE, 32'h0);
        sz1 = flit_count;
        reg_write(1, REG_SEND_CTRL, 32'h0);
        reg_read(1, REG_ERRORS, r);
        check("zero size flag", 32'h2, r);
        repeat (20) @(negedge clk);
        check("no flits from refused start", sz1, flit_count);
        reg_write(0, REG_ERRORS, 32'h80);
        reg_read(0, REG_ERRORS, r);
        check("errors cleared ch0", 32'h0, r);
        reg_read(1, REG_ERRORS, r);
        check("errors cleared ch1", 32'h0, r);
        reg_read(0, REG_IRQ_CTRL, r);
        check("error isr cleared", 32'h0, r & 32'h80);
        @(negedge clk);
        check("irq after clear", 0, irq_o);

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: flist.f
src/ni_pkg.sv
src/ni_slave_regs.sv
src/ni_send_channel.sv
src/ni_send_arbiter.sv
src/ni_ovc_credit.sv
src/ni_packetizer.sv
src/ni_send_top.sv
verification/ni_tb_clock.sv
verification/ni_send_properties.sv
verification/ni_send_tb.sv

// File: Bender.yml
package:
  name: ni_send

sources:
  - src/ni_pkg.sv
  - src/ni_slave_regs.sv
  - src/ni_send_channel.sv
  - src/ni_send_arbiter.sv
  - src/ni_ovc_credit.sv
  - src/ni_packetizer.sv
  - src/ni_send_top.sv
  - target: test
    files:
      - verification/ni_tb_clock.sv
      - verification/ni_send_properties.sv
      - verification/ni_send_tb.sv
